//--- exu_pkg.sv
package exu_pkg;

    // major opcodes
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    // funct3 for stores
    localparam logic [2:0] f3_sb   = 3'b000;
    localparam logic [2:0] f3_sh   = 3'b001;
    localparam logic [2:0] f3_sw   = 3'b010;
    // funct3 for addi within op-imm
    localparam logic [2:0] f3_addi = 3'b000;

    // store size code toward memory
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;
    localparam logic [1:0] size_idle = 2'd3;

    // instruction word seen through I-format and S-format views
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0]  imm_hi;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm_lo;
            logic [6:0]  opcode;
        } s_fmt;
    } instr_u;

endpackage

//--- instr_decode.sv
module instr_decode (
    hclk,
    hrstn,
    instr_valid,
    instr,
    instr_ready,
    dec_valid,
    dec_is_store,
    dec_size,
    dec_rs1,
    dec_rs2,
    dec_rd,
    dec_imm,
    dec_ready
);
input               hclk;
input               hrstn;
input               instr_valid;
input        [31:0] instr;
output logic        instr_ready;
output logic        dec_valid;
output logic        dec_is_store;
output logic [1:0]  dec_size;
output logic [4:0]  dec_rs1;
output logic [4:0]  dec_rs2;
output logic [4:0]  dec_rd;
output logic [11:0] dec_imm;
input               dec_ready;

exu_pkg::instr_u iw;
logic            is_store;
logic            is_addi;
logic [1:0]      st_size;

assign iw = instr;

always_comb begin
    is_addi  = (iw.i_fmt.opcode == exu_pkg::opc_op_imm) && (iw.i_fmt.funct3 == exu_pkg::f3_addi);
    is_store = iw.s_fmt.opcode == exu_pkg::opc_store;
    case (iw.s_fmt.funct3)
        exu_pkg::f3_sb: st_size = exu_pkg::size_byte;
        exu_pkg::f3_sh: st_size = exu_pkg::size_half;
        exu_pkg::f3_sw: st_size = exu_pkg::size_word;
        default: begin
            // unsupported store width is dropped like an illegal opcode
            st_size  = exu_pkg::size_idle;
            is_store = 1'b0;
        end
    endcase
end

// slot may refill in the same cycle it drains
assign instr_ready = !dec_valid || dec_ready;

always_ff @(posedge hclk or negedge hrstn) begin
    if (!hrstn) begin
        dec_valid <= 1'b0;
    end else if (instr_valid && instr_ready) begin
        dec_valid <= is_store || is_addi;
    end else if (dec_ready) begin
        dec_valid <= 1'b0;
    end
end

always_ff @(posedge hclk) begin
    if (instr_valid && instr_ready) begin
        dec_is_store <= is_store;
        dec_size     <= is_store ? st_size : exu_pkg::size_idle;
        dec_rs1      <= iw.i_fmt.rs1;
        dec_rs2      <= is_store ? iw.s_fmt.rs2 : 5'd0;
        dec_rd       <= is_addi ? iw.i_fmt.rd : 5'd0;
        dec_imm      <= is_store ? {iw.s_fmt.imm_hi, iw.s_fmt.imm_lo} : iw.i_fmt.imm;
    end
end

endmodule

//--- reg_file.sv
module reg_file (
    hclk,
    hrstn,
    reg_raddr_1,
    reg_ren_1,
    reg_rdata_1,
    reg_raddr_2,
    reg_ren_2,
    reg_rdata_2,
    reg_waddr,
    reg_wen,
    reg_wdata
);
input               hclk;
input               hrstn;
input        [4:0]  reg_raddr_1;
input               reg_ren_1;
output logic [31:0] reg_rdata_1;
input        [4:0]  reg_raddr_2;
input               reg_ren_2;
output logic [31:0] reg_rdata_2;
input        [4:0]  reg_waddr;
input               reg_wen;
input        [31:0] reg_wdata;

logic [31:0] regs [32];

always_ff @(posedge hclk or negedge hrstn) begin
    if (!hrstn) begin
        for (int i = 0; i < 32; i++) begin
            regs[i] <= 32'd0;
        end
        reg_rdata_1 <= 32'd0;
        reg_rdata_2 <= 32'd0;
    end else begin
        // x0 is never written
        if (reg_wen && (reg_waddr != 5'd0)) begin
            regs[reg_waddr] <= reg_wdata;
        end
        // read data holds until the next enable
        if (reg_ren_1) begin
            reg_rdata_1 <= (reg_raddr_1 == 5'd0) ? 32'd0 : regs[reg_raddr_1];
        end
        if (reg_ren_2) begin
            reg_rdata_2 <= (reg_raddr_2 == 5'd0) ? 32'd0 : regs[reg_raddr_2];
        end
    end
end

endmodule

//--- exu_store_swc.sv
module exu_store_swc (
    hclk,
    hrstn,
    dec_valid,
    dec_ready,
    dec_is_store,
    dec_size,
    dec_rs1,
    dec_rs2,
    dec_rd,
    dec_imm,
    reg_raddr_1,
    reg_ren_1,
    reg_rdata_1,
    reg_raddr_2,
    reg_ren_2,
    reg_rdata_2,
    reg_waddr,
    reg_wen,
    reg_wdata,
    ex_valid,
    ex_addr,
    ex_data,
    ex_size,
    ex_ready
);
input               hclk;
input               hrstn;
// decoded instruction
input               dec_valid;
output logic        dec_ready;
input               dec_is_store;
input        [1:0]  dec_size;
input        [4:0]  dec_rs1;
input        [4:0]  dec_rs2;
input        [4:0]  dec_rd;
input        [11:0] dec_imm;
// register file
output logic [4:0]  reg_raddr_1;
output logic        reg_ren_1;
input        [31:0] reg_rdata_1;
output logic [4:0]  reg_raddr_2;
output logic        reg_ren_2;
input        [31:0] reg_rdata_2;
output logic [4:0]  reg_waddr;
output logic        reg_wen;
output logic [31:0] reg_wdata;
// toward the store port
output logic        ex_valid;
output logic [31:0] ex_addr;
output logic [31:0] ex_data;
output logic [1:0]  ex_size;
input               ex_ready;

// 0 idle, 1 read, 2 data back, 3 compute, 4 waiting on ex_ready
logic [2:0]  cycle_cnt;
logic        dec_fire;
logic        is_store;
logic [1:0]  size;
logic [4:0]  rd;
logic [11:0] imm;
logic [31:0] sum;
logic [31:0] data_ext;

assign dec_ready = (cycle_cnt == 3'd0);
assign dec_fire  = dec_valid && dec_ready;

// shared by store address and addi result
assign sum = reg_rdata_1 + {{20{imm[11]}}, imm};

always_comb begin
    case (size)
        exu_pkg::size_byte: data_ext = {24'd0, reg_rdata_2[7:0]};
        exu_pkg::size_half: data_ext = {16'd0, reg_rdata_2[15:0]};
        default:            data_ext = reg_rdata_2;
    endcase
end

// addi commits on the edge closing cycle 3
assign reg_wen   = (cycle_cnt == 3'd3) && !is_store;
assign reg_waddr = rd;
assign reg_wdata = sum;

always_ff @(posedge hclk or negedge hrstn) begin
    if (!hrstn) begin
        cycle_cnt <= 3'd0;
        reg_ren_1 <= 1'b0;
        reg_ren_2 <= 1'b0;
        ex_valid  <= 1'b0;
        ex_size   <= exu_pkg::size_idle;
    end else begin
        reg_ren_1 <= 1'b0;
        reg_ren_2 <= 1'b0;
        case (cycle_cnt)
            3'd0: begin
                if (dec_fire) begin
                    cycle_cnt <= 3'd1;
                    reg_ren_1 <= 1'b1;
                    reg_ren_2 <= dec_is_store;
                end
            end
            3'd1: cycle_cnt <= 3'd2;
            3'd2: cycle_cnt <= 3'd3;
            3'd3: begin
                if (is_store) begin
                    cycle_cnt <= 3'd4;
                    ex_valid  <= 1'b1;
                    ex_size   <= size;
                end else begin
                    cycle_cnt <= 3'd0;
                end
            end
            default: begin
                if (ex_ready) begin
                    cycle_cnt <= 3'd0;
                    ex_valid  <= 1'b0;
                end
            end
        endcase
    end
end

always_ff @(posedge hclk) begin
    if (dec_fire) begin
        reg_raddr_1 <= dec_rs1;
        reg_raddr_2 <= dec_rs2;
        is_store    <= dec_is_store;
        size        <= dec_size;
        rd          <= dec_rd;
        imm         <= dec_imm;
    end
    if ((cycle_cnt == 3'd3) && is_store) begin
        ex_addr <= sum;
        ex_data <= data_ext;
    end
end

endmodule

//--- store_bus_if.sv
module store_bus_if (
    hclk,
    hrstn,
    ex_valid,
    ex_addr,
    ex_data,
    ex_size,
    ex_ready,
    store_valid,
    store_addr,
    store_data,
    store_strb,
    store_size,
    store_ready
);
input               hclk;
input               hrstn;
input               ex_valid;
input        [31:0] ex_addr;
input        [31:0] ex_data;
input        [1:0]  ex_size;
output logic        ex_ready;
output logic        store_valid;
output logic [31:0] store_addr;
output logic [31:0] store_data;
output logic [3:0]  store_strb;
output logic [1:0]  store_size;
input               store_ready;

logic [31:0] lane_data;
logic [3:0]  lane_strb;

// low address bits below the size are ignored
always_comb begin
    case (ex_size)
        exu_pkg::size_byte: begin
            lane_data = {4{ex_data[7:0]}};
            lane_strb = 4'b0001 << ex_addr[1:0];
        end
        exu_pkg::size_half: begin
            lane_data = {2{ex_data[15:0]}};
            lane_strb = ex_addr[1] ? 4'b1100 : 4'b0011;
        end
        exu_pkg::size_word: begin
            lane_data = ex_data;
            lane_strb = 4'b1111;
        end
        default: begin
            lane_data = ex_data;
            lane_strb = 4'b0000;
        end
    endcase
end

assign ex_ready = !store_valid || store_ready;

always_ff @(posedge hclk or negedge hrstn) begin
    if (!hrstn) begin
        store_valid <= 1'b0;
        store_size  <= exu_pkg::size_idle;
    end else if (ex_valid && ex_ready) begin
        store_valid <= 1'b1;
        store_size  <= ex_size;
    end else if (store_ready) begin
        store_valid <= 1'b0;
        store_size  <= exu_pkg::size_idle;
    end
end

always_ff @(posedge hclk) begin
    if (ex_valid && ex_ready) begin
        store_addr <= ex_addr;
        store_data <= lane_data;
        store_strb <= lane_strb;
    end
end

endmodule

//--- exu_store_top.sv
module exu_store_top (
    hclk,
    hrstn,
    instr_valid,
    instr,
    instr_ready,
    store_valid,
    store_addr,
    store_data,
    store_strb,
    store_size,
    store_ready
);
input         hclk;
input         hrstn;
input         instr_valid;
input  [31:0] instr;
output        instr_ready;
output        store_valid;
output [31:0] store_addr;
output [31:0] store_data;
output [3:0]  store_strb;
output [1:0]  store_size;
input         store_ready;

// decoder to sequencer
logic        dec_valid;
logic        dec_ready;
logic        dec_is_store;
logic [1:0]  dec_size;
logic [4:0]  dec_rs1;
logic [4:0]  dec_rs2;
logic [4:0]  dec_rd;
logic [11:0] dec_imm;
// register file ports
logic [4:0]  reg_raddr_1;
logic        reg_ren_1;
logic [31:0] reg_rdata_1;
logic [4:0]  reg_raddr_2;
logic        reg_ren_2;
logic [31:0] reg_rdata_2;
logic [4:0]  reg_waddr;
logic        reg_wen;
logic [31:0] reg_wdata;
// sequencer to store port
logic        ex_valid;
logic        ex_ready;
logic [31:0] ex_addr;
logic [31:0] ex_data;
logic [1:0]  ex_size;

instr_decode u_instr_decode (
    .hclk(hclk), .hrstn(hrstn),
    .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
    .dec_valid(dec_valid), .dec_is_store(dec_is_store), .dec_size(dec_size),
    .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd), .dec_imm(dec_imm),
    .dec_ready(dec_ready)
);

reg_file u_reg_file (
    .hclk(hclk), .hrstn(hrstn),
    .reg_raddr_1(reg_raddr_1), .reg_ren_1(reg_ren_1), .reg_rdata_1(reg_rdata_1),
    .reg_raddr_2(reg_raddr_2), .reg_ren_2(reg_ren_2), .reg_rdata_2(reg_rdata_2),
    .reg_waddr(reg_waddr), .reg_wen(reg_wen), .reg_wdata(reg_wdata)
);

exu_store_swc u_exu_store_swc (
    .hclk(hclk), .hrstn(hrstn),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_is_store(dec_is_store),
    .dec_size(dec_size), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd),
    .dec_imm(dec_imm),
    .reg_raddr_1(reg_raddr_1), .reg_ren_1(reg_ren_1), .reg_rdata_1(reg_rdata_1),
    .reg_raddr_2(reg_raddr_2), .reg_ren_2(reg_ren_2), .reg_rdata_2(reg_rdata_2),
    .reg_waddr(reg_waddr), .reg_wen(reg_wen), .reg_wdata(reg_wdata),
    .ex_valid(ex_valid), .ex_addr(ex_addr), .ex_data(ex_data), .ex_size(ex_size),
    .ex_ready(ex_ready)
);

store_bus_if u_store_bus_if (
    .hclk(hclk), .hrstn(hrstn),
    .ex_valid(ex_valid), .ex_addr(ex_addr), .ex_data(ex_data), .ex_size(ex_size),
    .ex_ready(ex_ready),
    .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
    .store_strb(store_strb), .store_size(store_size), .store_ready(store_ready)
);

endmodule

//--- tb_exu_store.sv
module tb_exu_store;

timeunit 1ns;
timeprecision 1ps;

logic        hclk;
logic        hrstn;
logic        instr_valid;
logic [31:0] instr;
logic        instr_ready;
logic        store_valid;
logic [31:0] store_addr;
logic [31:0] store_data;
logic [3:0]  store_strb;
logic [1:0]  store_size;
logic        store_ready;

// stimulus table with the expected store for each row
logic [31:0] tbl_word [48];
int          tbl_test [48];
bit          tbl_is_store [48];
logic [31:0] tbl_addr [48];
logic [31:0] tbl_data [48];
logic [3:0]  tbl_strb [48];
logic [1:0]  tbl_size [48];
int          n_rows;
int          exp_rows [48];
int          n_exp;

int errors;
int mon_errors = 0;
int xfer_count = 0;
bit timed_out;
bit bp_en;
bit gap_en;

exu_store_top DUT (
    .hclk(hclk), .hrstn(hrstn),
    .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
    .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
    .store_strb(store_strb), .store_size(store_size), .store_ready(store_ready)
);

initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
end

function automatic logic [31:0] enc_addi(input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), exu_pkg::f3_addi, 5'(rd), exu_pkg::opc_op_imm};
endfunction

function automatic logic [31:0] enc_store(input logic [1:0] size, input int rs2, input int rs1,
                                          input logic [11:0] imm);
    logic [2:0] f3;
    case (size)
        exu_pkg::size_byte: f3 = exu_pkg::f3_sb;
        exu_pkg::size_half: f3 = exu_pkg::f3_sh;
        default:            f3 = exu_pkg::f3_sw;
    endcase
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], exu_pkg::opc_store};
endfunction

// prints the error line and returns 1 on a wrong value
function automatic int report_mismatch(input string name, input logic [31:0] got,
                                       input logic [31:0] exp);
    if (got !== exp) begin
        $display("error at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
        return 1;
    end
    return 0;
endfunction

function automatic string test_name(input int t);
    case (t)
        1: return "reset and word store";
        2: return "byte stores";
        3: return "half stores";
        4: return "x0 and illegal opcodes";
        5: return "back-pressure and gaps";
        default: return "unknown";
    endcase
endfunction

task automatic add_row(input int t, input logic [31:0] word, input bit is_st,
                       input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input logic [1:0] size);
    tbl_test[n_rows] = t;
    tbl_word[n_rows] = word;
    tbl_is_store[n_rows] = is_st;
    tbl_addr[n_rows] = addr;
    tbl_data[n_rows] = data;
    tbl_strb[n_rows] = strb;
    tbl_size[n_rows] = size;
    if (is_st) begin
        exp_rows[n_exp] = n_rows;
        n_exp++;
    end
    n_rows++;
endtask

task automatic add_addi(input int t, input int rd, input int rs1, input logic [11:0] imm);
    add_row(t, enc_addi(rd, rs1, imm), 1'b0, 32'd0, 32'd0, 4'd0, exu_pkg::size_idle);
endtask

task automatic add_other(input int t, input logic [31:0] word);
    add_row(t, word, 1'b0, 32'd0, 32'd0, 4'd0, exu_pkg::size_idle);
endtask

task automatic add_store(input int t, input logic [1:0] size, input int rs2, input int rs1,
                         input logic [11:0] imm, input logic [31:0] addr,
                         input logic [31:0] data, input logic [3:0] strb);
    add_row(t, enc_store(size, rs2, rs1, imm), 1'b1, addr, data, strb, size);
endtask

task automatic build_table();
    n_rows = 0;
    n_exp = 0;
    // x5 = 0x100, x6 = 0xfffffaab
    add_addi(1, 5, 0, 12'h100);
    add_addi(1, 6, 0, 12'haab);
    add_store(1, exu_pkg::size_word, 6, 5, 12'h020, 32'h120, 32'hfffffaab, 4'b1111);
    add_store(2, exu_pkg::size_byte, 6, 5, 12'h000, 32'h100, 32'habababab, 4'b0001);
    add_store(2, exu_pkg::size_byte, 6, 5, 12'h001, 32'h101, 32'habababab, 4'b0010);
    add_store(2, exu_pkg::size_byte, 6, 5, 12'h002, 32'h102, 32'habababab, 4'b0100);
    add_store(2, exu_pkg::size_byte, 6, 5, 12'hfff, 32'h0ff, 32'habababab, 4'b1000);
    add_store(2, exu_pkg::size_byte, 6, 5, 12'hf82, 32'h082, 32'habababab, 4'b0100);
    add_addi(3, 7, 0, 12'h234);
    add_store(3, exu_pkg::size_half, 7, 5, 12'h010, 32'h110, 32'h02340234, 4'b0011);
    add_store(3, exu_pkg::size_half, 7, 5, 12'h012, 32'h112, 32'h02340234, 4'b1100);
    add_store(3, exu_pkg::size_half, 7, 5, 12'h013, 32'h113, 32'h02340234, 4'b1100);
    add_store(3, exu_pkg::size_half, 7, 5, 12'h011, 32'h111, 32'h02340234, 4'b0011);
    add_store(3, exu_pkg::size_half, 7, 5, 12'hffe, 32'h0fe, 32'h02340234, 4'b1100);
    add_store(4, exu_pkg::size_word, 6, 0, 12'h040, 32'h040, 32'hfffffaab, 4'b1111);
    add_store(4, exu_pkg::size_word, 0, 5, 12'h044, 32'h144, 32'h00000000, 4'b1111);
    add_addi(4, 0, 0, 12'h077);
    add_other(4, 32'h00b50533);
    add_other(4, 32'hffffffff);
    add_store(4, exu_pkg::size_word, 0, 0, 12'h048, 32'h048, 32'h00000000, 4'b1111);
    add_store(4, exu_pkg::size_word, 5, 0, 12'h000, 32'h000, 32'h00000100, 4'b1111);
    // x9 = 0x7f1, x10 = 0xfffffff1
    add_addi(5, 9, 0, 12'h7f1);
    add_addi(5, 10, 9, 12'h800);
    add_store(5, exu_pkg::size_word, 10, 9, 12'h000, 32'h7f1, 32'hfffffff1, 4'b1111);
    add_store(5, exu_pkg::size_byte, 9, 10, 12'h003, 32'hfffffff4, 32'hf1f1f1f1, 4'b0001);
    add_store(5, exu_pkg::size_half, 10, 9, 12'hffc, 32'h7ed, 32'hfff1fff1, 4'b0011);
    add_store(5, exu_pkg::size_word, 9, 0, 12'h7ff, 32'h7ff, 32'h000007f1, 4'b1111);
    add_store(5, exu_pkg::size_byte, 10, 9, 12'h800, 32'hfffffff1, 32'hf1f1f1f1, 4'b0010);
    add_store(5, exu_pkg::size_half, 9, 9, 12'h002, 32'h7f3, 32'h07f107f1, 4'b1100);
    add_addi(5, 9, 9, 12'h001);
    add_store(5, exu_pkg::size_word, 9, 0, 12'h000, 32'h000, 32'h000007f2, 4'b1111);
    add_store(5, exu_pkg::size_byte, 9, 10, 12'h7fe, 32'h7ef, 32'hf2f2f2f2, 4'b1000);
    add_store(5, exu_pkg::size_half, 10, 0, 12'h7ff, 32'h7ff, 32'hfff1fff1, 4'b1100);
endtask

// memory side ready about one cycle in four under back-pressure
initial begin
    bit nxt;
    store_ready = 1'b1;
    forever begin
        @(posedge hclk);
        nxt = bp_en ? (($urandom % 4) == 0) : 1'b1;
        @(negedge hclk);
        store_ready = nxt;
    end
end

always @(posedge hclk) begin
    int idx;
    if (hrstn && store_valid && store_ready) begin
        if (xfer_count >= n_exp) begin
            $display("unexpected store transfer at %0d ns to address 0x%h", $time, store_addr);
            mon_errors++;
        end else begin
            idx = exp_rows[xfer_count];
            mon_errors += report_mismatch("store_addr", store_addr, tbl_addr[idx]);
            mon_errors += report_mismatch("store_data", store_data, tbl_data[idx]);
            mon_errors += report_mismatch("store_strb", {28'd0, store_strb},
                                          {28'd0, tbl_strb[idx]});
            mon_errors += report_mismatch("store_size", {30'd0, store_size},
                                          {30'd0, tbl_size[idx]});
        end
        xfer_count++;
    end
end

task automatic send_instr(input int i);
    int  gap;
    int  wait_cnt;
    bit  accepted;
    gap = 0;
    if (gap_en) begin
        gap = $urandom % 4;
    end
    repeat (gap) @(negedge hclk);
    instr = tbl_word[i];
    instr_valid = 1'b1;
    accepted = 1'b0;
    wait_cnt = 0;
    while (!accepted && wait_cnt < 100) begin
        @(posedge hclk);
        accepted = instr_ready;
        wait_cnt++;
    end
    @(negedge hclk);
    instr_valid = 1'b0;
    if (!accepted) begin
        $display("timeout: instr_ready stayed low while sending table row %0d", i);
        errors++;
        timed_out = 1'b1;
    end
endtask

task automatic run_test(input int t);
    int err_start;
    int target;
    int wait_cnt;
    err_start = errors + mon_errors;
    bp_en = (t == 5);
    gap_en = (t == 5);
    if (t == 1) begin
        errors += report_mismatch("store_valid", {31'd0, store_valid}, 32'd0);
        errors += report_mismatch("instr_ready", {31'd0, instr_ready}, 32'd1);
        errors += report_mismatch("store_size", {30'd0, store_size},
                                  {30'd0, exu_pkg::size_idle});
    end
    target = 0;
    for (int i = 0; i < n_rows; i++) begin
        if (tbl_test[i] <= t && tbl_is_store[i]) begin
            target++;
        end
    end
    for (int i = 0; i < n_rows && !timed_out; i++) begin
        if (tbl_test[i] == t) begin
            send_instr(i);
        end
    end
    wait_cnt = 0;
    while (!timed_out && xfer_count < target && wait_cnt < 400) begin
        @(negedge hclk);
        wait_cnt++;
    end
    if (!timed_out && xfer_count < target) begin
        $display("timeout: test %0d saw only %0d of %0d store transfers", t, xfer_count, target);
        errors++;
        timed_out = 1'b1;
    end
    if (t == 5 && !timed_out) begin
        // let any stray transfer show up
        bp_en = 1'b0;
        repeat (20) @(negedge hclk);
        errors += report_mismatch("store transfer count", xfer_count, n_exp);
    end
    $display("test %0d (%s) finished with %0d errors", t, test_name(t),
             errors + mon_errors - err_start);
endtask

initial begin
    int t;
    hrstn = 1'b0;
    instr_valid = 1'b0;
    instr = 32'd0;
    errors = 0;
    timed_out = 1'b0;
    bp_en = 1'b0;
    gap_en = 1'b0;
    void'($urandom(32'hb3ff));
    build_table();
    repeat (8) @(negedge hclk);
    hrstn = 1'b1;
    @(negedge hclk);
    t = 1;
    while (t <= 5 && !timed_out) begin
        run_test(t);
        t++;
    end
    $display("summary: %0d store transfers of %0d expected, %0d errors", xfer_count, n_exp,
             errors + mon_errors);
    if (errors + mon_errors == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

endmodule

//--- src.f
exu_pkg.sv
instr_decode.sv
reg_file.sv
exu_store_swc.sv
store_bus_if.sv
exu_store_top.sv
tb_exu_store.sv

//--- run.sh
#!/bin/sh
# build and run the store subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_exu_store --Mdir obj_dir -o sim_exu_store > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_exu_store > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
